//--- verilog/psgPkg.sv
package psgPkg;

	// ======================================================================
	// sizes
	// ======================================================================

	// wavetable channels sharing one memory bus
	localparam int NumChannels = 8;
	localparam int ChanBits = 3;

	// memory word address and sample widths
	localparam int AdrWidth = 16;
	localparam int SampleWidth = 16;

	// eight 16-bit samples need three extra bits of headroom
	localparam int MixWidth = 19;

	// ce ticks per sample
	localparam int PeriodWidth = 8;

	// ======================================================================
	// enums
	// ======================================================================

	// configuration target of a write strobe
	typedef enum logic [1:0] {
		CfgBase,
		CfgLength,
		CfgPeriod,
		CfgEnable
	} psgCfgField_e;

	typedef enum logic {
		BusIdle,
		BusActive
	} psgBusState_e;

	// ======================================================================
	// structs
	// ======================================================================

	// one configuration write, data carries a base address, a length,
	// a period or an enable mask
	typedef struct packed {
		logic we;
		logic [ChanBits-1:0] chan;
		psgCfgField_e field;
		logic [AdrWidth-1:0] data;
	} psgCfg_t;

	// arbiter output, one-hot select plus owner index
	typedef struct packed {
		logic [NumChannels-1:0] sel;
		logic [ChanBits-1:0] seln;
	} psgGrant_t;

	// sample returned from memory, tagged with its channel
	typedef struct packed {
		logic valid;
		logic [ChanBits-1:0] chan;
		logic signed [SampleWidth-1:0] data;
	} psgFetch_t;

endpackage

//--- verilog/psgBusArb.sv
`timescale 1ns/1ps

module psgBusArb (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busFree,
	input logic [psgPkg::NumChannels-1:0] req,
	output psgPkg::psgGrant_t grant
);

	logic [psgPkg::NumChannels-1:0] nextSel;
	logic [psgPkg::ChanBits-1:0] nextSeln;
	logic anyReq;

	// ======================================================================
	// priority pick, lowest index wins
	// ======================================================================

	// scan from the top down so the lowest requester is written last
	always_comb begin
		nextSel = '0;
		nextSeln = '0;
		for (int i = psgPkg::NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextSel = '0;
				nextSel[i] = 1'b1;
				nextSeln = psgPkg::ChanBits'(i);
			end
		end
	end

	assign anyReq = |req;

	// ======================================================================
	// grant register
	// ======================================================================

	// moves only on ce while the bus master is idle
	always_ff @(posedge clk) begin
		if (rst) begin
			grant.sel <= '0;
			grant.seln <= '0;
		end else if (ce && busFree && anyReq) begin
			grant.sel <= nextSel;
			grant.seln <= nextSeln;
		end
		// nobody asking, last owner keeps the bus
	end

endmodule

//--- verilog/psgWaveChannel.sv
`timescale 1ns/1ps

module psgWaveChannel (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgPkg::psgCfg_t cfg,
	input logic [psgPkg::ChanBits-1:0] chanId,
	input logic start,
	input logic [psgPkg::ChanBits-1:0] startChan,
	input psgPkg::psgFetch_t fetch,
	output logic req,
	output logic [psgPkg::AdrWidth-1:0] adr,
	output logic signed [psgPkg::SampleWidth-1:0] sample,
	output logic enable,
	output logic underrun
);

	logic [psgPkg::AdrWidth-1:0] base;
	logic [psgPkg::AdrWidth-1:0] length;
	logic [psgPkg::AdrWidth-1:0] index;
	logic [psgPkg::PeriodWidth-1:0] period;
	logic [psgPkg::PeriodWidth-1:0] timer;
	logic pending;
	logic cfgHit;
	logic enableWr;
	logic expire;
	logic startHit;
	logic fetchHit;

	assign cfgHit = cfg.we && (cfg.chan == chanId);
	assign enableWr = cfg.we && (cfg.field == psgPkg::CfgEnable);
	assign startHit = start && (startChan == chanId);
	assign fetchHit = fetch.valid && (fetch.chan == chanId);

	// timer reaches the programmed period on this ce tick
	assign expire = enable && ce && (timer + 1'b1 == period);

	assign adr = base + index;

	// ======================================================================
	// configuration
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			base <= '0;
			length <= '0;
			period <= '0;
			enable <= 1'b0;
		end else begin
			if (cfgHit && cfg.field == psgPkg::CfgBase)
				base <= cfg.data;
			if (cfgHit && cfg.field == psgPkg::CfgLength)
				length <= cfg.data;
			if (cfgHit && cfg.field == psgPkg::CfgPeriod)
				period <= cfg.data[psgPkg::PeriodWidth-1:0];
			// enable mask goes to all channels at once
			if (enableWr)
				enable <= cfg.data[chanId];
		end
	end

	// ======================================================================
	// timer, table walk and fetch request
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			timer <= '0;
			index <= '0;
			pending <= 1'b0;
			req <= 1'b0;
			sample <= '0;
			underrun <= 1'b0;
		end else begin
			if (enableWr)
				timer <= '0;
			else if (enable && ce)
				timer <= expire ? '0 : timer + 1'b1;

			// a new table restarts the walk
			if (cfgHit && (cfg.field == psgPkg::CfgBase || cfg.field == psgPkg::CfgLength))
				index <= '0;
			else if (fetchHit)
				index <= (index + 1'b1 == length) ? '0 : index + 1'b1;

			// bus master took the request
			if (startHit)
				req <= 1'b0;

			if (fetchHit) begin
				sample <= fetch.data;
				pending <= 1'b0;
			end

			if (expire) begin
				if (pending && !fetchHit) begin
					underrun <= 1'b1;
				end else begin
					pending <= 1'b1;
					req <= 1'b1;
				end
			end

			// clearing wins over a simultaneous expiry
			if (enableWr)
				underrun <= 1'b0;
		end
	end

endmodule

//--- verilog/psgBusMaster.sv
`timescale 1ns/1ps

module psgBusMaster (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgPkg::psgGrant_t grant,
	input logic [psgPkg::NumChannels-1:0] req,
	input logic [psgPkg::AdrWidth-1:0] chanAdr [psgPkg::NumChannels],
	output logic busFree,
	output logic start,
	output logic [psgPkg::ChanBits-1:0] startChan,
	output logic memCyc,
	output logic [psgPkg::AdrWidth-1:0] memAdr,
	input logic [psgPkg::SampleWidth-1:0] memDat,
	input logic memAck,
	output psgPkg::psgFetch_t fetch
);

	psgPkg::psgBusState_e state;
	logic [psgPkg::ChanBits-1:0] owner;
	logic launch;

	// owner still wants the bus on a ce tick
	assign launch = ce && (grant.sel != '0) && req[grant.seln];

	// arbiter may only move while no read is in flight
	assign busFree = (state == psgPkg::BusIdle);

	assign startChan = owner;

	// ======================================================================
	// read sequencer
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= psgPkg::BusIdle;
			owner <= '0;
			memCyc <= 1'b0;
			start <= 1'b0;
			fetch.valid <= 1'b0;
		end else begin
			start <= 1'b0;
			fetch.valid <= 1'b0;
			case (state)
				psgPkg::BusIdle: begin
					if (launch) begin
						// owner is captured here, the grant may change later
						owner <= grant.seln;
						memCyc <= 1'b1;
						start <= 1'b1;
						state <= psgPkg::BusActive;
					end
				end
				psgPkg::BusActive: begin
					// wait here as long as memory holds off the ack
					if (memAck) begin
						memCyc <= 1'b0;
						fetch.valid <= 1'b1;
						state <= psgPkg::BusIdle;
					end
				end
				default: state <= psgPkg::BusIdle;
			endcase
		end
	end

	// address and returned data
	always_ff @(posedge clk) begin
		if (state == psgPkg::BusIdle && launch)
			memAdr <= chanAdr[grant.seln];
		if (state == psgPkg::BusActive && memAck) begin
			fetch.chan <= owner;
			fetch.data <= memDat;
		end
	end

endmodule

//--- verilog/psgMixer.sv
`timescale 1ns/1ps

module psgMixer (
	input logic clk,
	input logic rst,
	input logic signed [psgPkg::SampleWidth-1:0] sample [psgPkg::NumChannels],
	input logic [psgPkg::NumChannels-1:0] enable,
	output logic signed [psgPkg::MixWidth-1:0] mixOut
);

	logic signed [psgPkg::MixWidth-1:0] sum;

	// ======================================================================
	// sum of enabled channels
	// ======================================================================

	// samples are sign extended before adding
	always_comb begin
		sum = '0;
		for (int i = 0; i < psgPkg::NumChannels; i++) begin
			if (enable[i])
				sum = sum + psgPkg::MixWidth'(sample[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			mixOut <= '0;
		else
			mixOut <= sum;
	end

endmodule

//--- verilog/psgFetchTop.sv
`timescale 1ns/1ps

module psgFetchTop (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgPkg::psgCfg_t cfg,
	input logic [psgPkg::SampleWidth-1:0] memDat,
	input logic memAck,
	output logic memCyc,
	output logic [psgPkg::AdrWidth-1:0] memAdr,
	output logic signed [psgPkg::MixWidth-1:0] mixOut,
	output logic [psgPkg::NumChannels-1:0] underrun
);

	logic [psgPkg::NumChannels-1:0] req;
	logic [psgPkg::AdrWidth-1:0] chanAdr [psgPkg::NumChannels];
	logic signed [psgPkg::SampleWidth-1:0] sample [psgPkg::NumChannels];
	logic [psgPkg::NumChannels-1:0] enable;
	psgPkg::psgGrant_t grant;
	psgPkg::psgFetch_t fetch;
	logic busFree;
	logic start;
	logic [psgPkg::ChanBits-1:0] startChan;

	// ======================================================================
	// wavetable channels
	// ======================================================================

	for (genvar i = 0; i < psgPkg::NumChannels; i++) begin : gChan
		psgWaveChannel psgWaveChannel_inst (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.cfg(cfg),
			.chanId(psgPkg::ChanBits'(i)),
			.start(start),
			.startChan(startChan),
			.fetch(fetch),
			.req(req[i]),
			.adr(chanAdr[i]),
			.sample(sample[i]),
			.enable(enable[i]),
			.underrun(underrun[i])
		);
	end

	// ======================================================================
	// shared memory bus
	// ======================================================================

	psgBusArb psgBusArb_inst (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busFree(busFree),
		.req(req),
		.grant(grant)
	);

	psgBusMaster psgBusMaster_inst (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.grant(grant),
		.req(req),
		.chanAdr(chanAdr),
		.busFree(busFree),
		.start(start),
		.startChan(startChan),
		.memCyc(memCyc),
		.memAdr(memAdr),
		.memDat(memDat),
		.memAck(memAck),
		.fetch(fetch)
	);

	// output mix
	psgMixer psgMixer_inst (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.enable(enable),
		.mixOut(mixOut)
	);

endmodule

//--- verification/psgFetchSva.sv
`timescale 1ns/1ps

module psgFetchSva (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busFree,
	input psgPkg::psgGrant_t grant,
	input logic [psgPkg::NumChannels-1:0] req,
	input logic start,
	input logic [psgPkg::ChanBits-1:0] startChan,
	input logic memCyc,
	input logic memAck
);

	// ======================================================================
	// arbiter grant
	// ======================================================================

	grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant.sel))
		else $error("grant select has more than one bit set");

	// grant only moves on a ce tick with the bus free
	grantHeld: assert property (@(posedge clk) disable iff (rst)
		(!ce || !busFree) |=> $stable(grant))
		else $error("grant changed without ce and a free bus");

	// ======================================================================
	// memory cycle
	// ======================================================================

	cycHeld: assert property (@(posedge clk) disable iff (rst)
		(memCyc && !memAck) |=> memCyc)
		else $error("memory cycle dropped before its acknowledge");

	startReq: assert property (@(posedge clk) disable iff (rst) start |-> req[startChan])
		else $error("start pulse for a channel that is not requesting");

endmodule

bind psgBusMaster psgFetchSva psgFetchSva_inst (.*);

//--- verification/psgFetchTb.sv
`timescale 1ns/1ps

module psgFetchTb;

	logic clk;
	logic rst;
	logic ce;
	psgPkg::psgCfg_t cfg;
	logic [15:0] memDat;
	logic memAck;
	logic memCyc;
	logic [psgPkg::AdrWidth-1:0] memAdr;
	logic signed [psgPkg::MixWidth-1:0] mixOut;
	logic [psgPkg::NumChannels-1:0] underrun;

	// memory model state
	logic [15:0] dataKey = 16'h5A3C;
	logic holdOff;
	logic armed;
	int ackDelay;
	int cycles;

	// reference model
	int baseM [8];
	int lenM [8];
	int idxM [8];
	int sampM [8];
	logic [7:0] enM;
	int sumPrev;
	logic ack1V;
	logic ack2V;
	int ack1C;
	int ack1D;
	int ack2C;
	int ack2D;
	psgPkg::psgCfg_t cfgPrev;
	logic prevCyc;
	logic [15:0] prevAdr;
	logic monOn;
	int readOrder [$];

	psgFetchTop psgFetchTop_inst (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.cfg(cfg),
		.memDat(memDat),
		.memAck(memAck),
		.memCyc(memCyc),
		.memAdr(memAdr),
		.mixOut(mixOut),
		.underrun(underrun)
	);

	always #5 clk = ~clk;

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic checkEq(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
			$display("TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic failNow(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic writeCfg(input int chan, input psgPkg::psgCfgField_e field, input int data);
		@(posedge clk);
		cfg.we <= 1'b1;
		cfg.chan <= chan[2:0];
		cfg.field <= field;
		cfg.data <= data[15:0];
		// a new table restarts the walk at index zero
		if (field == psgPkg::CfgBase) begin
			baseM[chan] = data;
			idxM[chan] = 0;
		end
		if (field == psgPkg::CfgLength) begin
			lenM[chan] = data;
			idxM[chan] = 0;
		end
		@(posedge clk);
		cfg.we <= 1'b0;
	endtask

	// no request, no cycle and no ack for a few cycles in a row
	task automatic waitQuiet();
		int calm;
		calm = 0;
		while (calm < 4) begin
			@(negedge clk);
			if (psgFetchTop_inst.req == '0 && !memCyc && !memAck)
				calm++;
			else
				calm = 0;
		end
	endtask

	task automatic loadTables(input int periodLo, input int periodSpan);
		for (int c = 0; c < 8; c++) begin
			writeCfg(c, psgPkg::CfgBase, c * 4096 + int'($urandom % 256));
			writeCfg(c, psgPkg::CfgLength, int'($urandom % 64) + 1);
			writeCfg(c, psgPkg::CfgPeriod, periodLo + int'($urandom % periodSpan));
		end
	endtask

	// ======================================================================
	// stimulus drivers and memory model
	// ======================================================================

	always @(posedge clk) begin
		ce <= ($urandom % 2) == 1;
	end

	always @(posedge clk) begin
		if (rst) begin
			memAck <= 1'b0;
			armed = 1'b0;
		end else if (memAck) begin
			memAck <= 1'b0;
		end else if (memCyc && !holdOff) begin
			if (!armed) begin
				ackDelay = int'($urandom % 4);
				armed = 1'b1;
			end
			if (ackDelay == 0) begin
				memAck <= 1'b1;
				memDat <= memAdr ^ dataKey;
				armed = 1'b0;
			end else begin
				ackDelay--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 20000)
			failNow("timeout, the run did not finish within 20000 cycles");
	end

	// ======================================================================
	// monitor and reference model, sampled mid-cycle
	// ======================================================================

	always @(negedge clk) begin
		int ch;
		int s;
		if (monOn) begin
			// mixer registers the sum of last cycle's samples and enables
			checkEq("mixOut", int'(mixOut), sumPrev);
			if (ack2V)
				sampM[ack2C] = ack2D;
			if (cfgPrev.we && cfgPrev.field == psgPkg::CfgEnable)
				enM = cfgPrev.data[7:0];
			ack2V = ack1V;
			ack2C = ack1C;
			ack2D = ack1D;
			ack1V = memCyc && memAck;
			ack1C = int'(memAdr >> 12);
			ack1D = int'($signed(memDat));
			cfgPrev = cfg;

			if (memCyc && !prevCyc) begin
				ch = int'(memAdr >> 12);
				if (ch > 7)
					failNow("read address lies outside every table region");
				checkEq("memAdr", int'(memAdr), baseM[ch] + idxM[ch]);
				idxM[ch] = (idxM[ch] + 1 == lenM[ch]) ? 0 : idxM[ch] + 1;
				readOrder.push_back(ch);
			end
			if (memCyc && prevCyc)
				checkEq("memAdr", int'(memAdr), int'(prevAdr));

			s = 0;
			for (int c = 0; c < 8; c++) begin
				if (enM[c])
					s += sampM[c];
			end
			sumPrev = s;
			prevCyc = memCyc;
			prevAdr = memAdr;
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		void'($urandom(38));
		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b0;
		cfg = '0;
		memDat = '0;
		memAck = 1'b0;
		holdOff = 1'b0;
		armed = 1'b0;
		ackDelay = 0;
		cycles = 0;
		enM = '0;
		sumPrev = 0;
		ack1V = 1'b0;
		ack2V = 1'b0;
		cfgPrev = '0;
		prevCyc = 1'b0;
		prevAdr = '0;
		monOn = 1'b0;
		for (int c = 0; c < 8; c++) begin
			baseM[c] = 0;
			lenM[c] = 0;
			idxM[c] = 0;
			sampM[c] = 0;
		end

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		monOn <= 1'b1;

		// quiet after reset
		repeat (20) begin
			@(negedge clk);
			checkEq("memCyc", int'(memCyc), 0);
			checkEq("mixOut", int'(mixOut), 0);
			checkEq("underrun", int'(underrun), 0);
		end

		// equal periods, all requests pending before the first grant
		loadTables(100, 1);
		readOrder.delete();
		writeCfg(0, psgPkg::CfgEnable, 16'h00FF);
		while (readOrder.size() < 8)
			@(negedge clk);
		for (int i = 0; i < 8; i++)
			checkEq("read channel", readOrder[i], i);
		repeat (600) @(posedge clk);
		writeCfg(0, psgPkg::CfgEnable, 0);
		waitQuiet();

		// random tables, periods and enable masks
		for (int round = 0; round < 3; round++) begin
			loadTables(16, 45);
			writeCfg(0, psgPkg::CfgEnable, int'($urandom % 256));
			repeat (750) @(posedge clk);
			writeCfg(0, psgPkg::CfgEnable, int'($urandom % 256));
			repeat (750) @(posedge clk);
			writeCfg(0, psgPkg::CfgEnable, 0);
			waitQuiet();
		end

		// memory holds off its ack while every channel runs fast
		loadTables(2, 1);
		@(posedge clk);
		holdOff <= 1'b1;
		writeCfg(0, psgPkg::CfgEnable, 16'h00FF);
		repeat (300) @(posedge clk);
		@(negedge clk);
		checkEq("memCyc", int'(memCyc), 1);
		checkEq("underrun", int'(underrun), 255);
		@(posedge clk);
		holdOff <= 1'b0;
		writeCfg(0, psgPkg::CfgEnable, 0);
		waitQuiet();
		checkEq("underrun", int'(underrun), 0);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- src.f
verilog/psgPkg.sv
verilog/psgBusArb.sv
verilog/psgWaveChannel.sv
verilog/psgBusMaster.sv
verilog/psgMixer.sv
verilog/psgFetchTop.sv
verification/psgFetchSva.sv
verification/psgFetchTb.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP = psgFetchTb
FILELIST = src.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the run prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
